// File: hdl/dis_pkg.sv
// Dispatch stage package with widths, field positions and the execute-stage payload
`default_nettype none

package dis_pkg;

    // ------------------------------------------------------------
    // Word and register widths
    // ------------------------------------------------------------
    localparam int xlen = 32;                 // Data word width

    typedef logic [4:0]      reg_addr_t;      // GPR index
    typedef logic [xlen-1:0] word_t;          // Data word

    // ------------------------------------------------------------
    // Functional unit one-hot and micro-op fields
    // ------------------------------------------------------------
    localparam int p_fu_alu = 0;              // Integer ALU
    localparam int p_fu_mul = 1;              // Multiply / divide
    localparam int p_fu_lsu = 2;              // Load / store unit
    localparam int p_fu_cfu = 3;              // Control flow unit
    localparam int p_fu_csr = 4;              // CSR access

    localparam int lsu_store = 4;             // Uop bit set for stores

    localparam logic [1:0] cfu_cond_code = 2'b00; // Uop[4:3] of a conditional branch

    // ------------------------------------------------------------
    // Operand source select positions
    // ------------------------------------------------------------
    localparam int dis_opra_rs1  = 0;         // A from rs1
    localparam int dis_opra_pcim = 1;         // A from pc + imm
    localparam int dis_opra_csri = 2;         // A from CSR immediate
    localparam int dis_oprb_rs2  = 3;         // B from rs2
    localparam int dis_oprb_imm  = 4;         // B from immediate
    localparam int dis_oprc_rs2  = 5;         // C from rs2
    localparam int dis_oprc_csra = 6;         // C from CSR address
    localparam int dis_oprc_pcim = 7;         // C from pc + imm

    // Payload carried into the execute stage
    typedef struct packed {
        reg_addr_t  rd;                       // Destination, or trap cause
        word_t      pc;                       // Instruction address
        logic [4:0] uop;                      // Micro-op code
        logic [4:0] fu;                       // Functional unit one-hot
        logic [1:0] size;                     // 16 or 32 bit encoding
        logic [31:0] instr;                   // Raw instruction word
        word_t      opr_a;                    // Operand A
        word_t      opr_b;                    // Operand B
        word_t      opr_c;                    // Operand C
        logic       trap;                     // Raise a trap
    } dis_s3_t;

endpackage

`default_nettype wire

// File: hdl/dis_fwd_if.sv
// Forwarding bundle carrying one later stage's result back to dispatch
`timescale 1ns/10ps
`default_nettype none

interface dis_fwd_if;
    import dis_pkg::*;

    reg_addr_t rd;                            // Destination register of the stage
    word_t     wdata;                         // Result the stage will write
    logic      load;                          // Stage holds a load
    logic      csr;                           // Stage holds a CSR op

    // Driven by the later stage
    modport source (
        output rd,
        output wdata,
        output load,
        output csr
    );

    // Read by dispatch
    modport sink (
        input rd,
        input wdata,
        input load,
        input csr
    );

endinterface

`default_nettype wire

// File: hdl/dis_gprs.sv
// General purpose register file, two async reads, one sync write, x0 tied to zero
`timescale 1ns/10ps
`default_nettype none

module dis_gprs (
    input  wire                g_clk,
    input  wire                g_resetn,
    input  dis_pkg::reg_addr_t rs1_addr,      // Read port 1 index
    output dis_pkg::word_t     rs1_data,      // Read port 1 data
    input  dis_pkg::reg_addr_t rs2_addr,      // Read port 2 index
    output dis_pkg::word_t     rs2_data,      // Read port 2 data
    input  wire                rd_wen,        // Write enable
    input  dis_pkg::reg_addr_t rd_addr,       // Write index
    input  dis_pkg::word_t     rd_data        // Write data
);
    import dis_pkg::*;

    word_t regs [1:31];                       // x1..x31, x0 has no storage

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;         // Writes to x0 dropped
        end
    end

    // ------------------------------------------------------------
    // Read ports
    // ------------------------------------------------------------
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr]; // x0 reads zero
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: hdl/dis_pipe_reg.sv
// Single-entry execute-stage pipeline register with valid/busy flow control and flush
`timescale 1ns/10ps
`default_nettype none

module dis_pipe_reg (
    input  wire              g_clk,
    input  wire              g_resetn,
    input  dis_pkg::dis_s3_t i_data,          // Payload from dispatch
    input  wire              i_valid,         // Payload valid
    output logic             o_busy,          // Cannot take new data
    input  wire              flush,           // Empty the entry
    output dis_pkg::dis_s3_t o_data,          // Payload to execute
    output logic             o_valid,         // Entry holds a payload
    input  wire              i_busy           // Execute stalled
);
    import dis_pkg::*;

    logic hold;                               // Entry stuck behind execute

    assign hold   = o_valid && i_busy;
    assign o_busy = hold;

    // ------------------------------------------------------------
    // Valid flag
    // ------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
        end else if (flush) begin
            o_valid <= 1'b0;                  // Slot emptied, payload left as is
        end else if (!hold) begin
            o_valid <= i_valid;
        end
    end

    // Payload only moves when not held
    always_ff @(posedge g_clk) begin
        if (!hold) begin
            o_data <= i_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dis_dispatch.sv
// Dispatch stage: PC tracking, hazard bubbles, operand forwarding and packing
`timescale 1ns/10ps
`default_nettype none

module dis_dispatch #(
    parameter dis_pkg::word_t pc_reset_value = 32'h8000_0000
) (
    input  wire                g_clk,
    input  wire                g_resetn,
    input  wire                s2_valid,      // Decode has an instruction
    output logic               s2_busy,       // Dispatch cannot accept
    input  dis_pkg::reg_addr_t s2_rd,
    input  dis_pkg::reg_addr_t s2_rs1,
    input  dis_pkg::reg_addr_t s2_rs2,
    input  dis_pkg::word_t     s2_imm,
    input  wire [4:0]          s2_uop,
    input  wire [4:0]          s2_fu,
    input  wire                s2_trap,
    input  wire [7:0]          s2_opr_src,    // Operand source one-hots
    input  wire [1:0]          s2_size,
    input  wire [31:0]         s2_instr,
    input  wire                flush,
    input  wire                cf_req,        // Control flow change request
    input  dis_pkg::word_t     cf_target,
    input  wire                cf_ack,
    dis_fwd_if.sink            fwd_s3,        // Execute stage result
    dis_fwd_if.sink            fwd_s4,        // Writeback stage result
    input  wire                gpr_wen,
    input  dis_pkg::reg_addr_t gpr_rd,
    input  dis_pkg::word_t     gpr_wdata,
    input  wire                s3_busy,
    output logic               s3_valid,
    output dis_pkg::dis_s3_t   s3_data
);
    import dis_pkg::*;

    word_t   program_counter;
    word_t   pc_plus_imm;
    word_t   csr_addr;
    word_t   csr_imm;
    word_t   gpr_rs1, gpr_rs2;                // Raw register file reads
    word_t   dis_rs1, dis_rs2;                // Reads after forwarding
    logic    dis_bubble;
    logic    p_busy, p_valid, p_flush;
    logic    fwd_s3_rs1, fwd_s4_rs1, fwd_s3_rs2, fwd_s4_rs2;
    logic    cfu_cond, no_rd;
    dis_s3_t n_s3;

    // ------------------------------------------------------------
    // Program counter, aligned to decode
    // ------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            program_counter <= pc_reset_value;
        end else if (cf_req && cf_ack) begin
            program_counter <= cf_target;     // Redirect wins over advance
        end else if (s2_valid && !s2_busy) begin
            program_counter <= program_counter + {29'b0, s2_size[1], s2_size[0], 1'b0};
        end
    end

    assign pc_plus_imm = program_counter + s2_imm;
    assign csr_addr    = {20'b0, s2_imm[31:20]};  // CSR index from imm
    assign csr_imm     = {27'b0, s2_rs1};         // uimm rides in rs1 field

    // ------------------------------------------------------------
    // Hazards
    // ------------------------------------------------------------
    // Load and CSR results are not ready in s3, CSR not in s4
    assign dis_bubble =
        ((fwd_s3.load || fwd_s3.csr) && (s2_rs1 == fwd_s3.rd || s2_rs2 == fwd_s3.rd)) ||
        (fwd_s4.csr && (s2_rs1 == fwd_s4.rd || s2_rs2 == fwd_s4.rd));

    assign s2_busy = dis_bubble || p_busy;
    assign p_valid = dis_bubble || s2_valid;
    assign p_flush = flush || (dis_bubble && !p_busy); // Bubble enters empty

    // ------------------------------------------------------------
    // Forwarding, s3 before s4 before the register file
    // ------------------------------------------------------------
    assign fwd_s3_rs1 = (s2_rs1 == fwd_s3.rd) && |s2_rs1;
    assign fwd_s4_rs1 = (s2_rs1 == fwd_s4.rd) && |s2_rs1;
    assign fwd_s3_rs2 = (s2_rs2 == fwd_s3.rd) && |s2_rs2;
    assign fwd_s4_rs2 = (s2_rs2 == fwd_s4.rd) && |s2_rs2;

    assign dis_rs1 = fwd_s3_rs1 ? fwd_s3.wdata :
                     fwd_s4_rs1 ? fwd_s4.wdata : gpr_rs1;
    assign dis_rs2 = fwd_s3_rs2 ? fwd_s3.wdata :
                     fwd_s4_rs2 ? fwd_s4.wdata : gpr_rs2;

    // ------------------------------------------------------------
    // Payload packing
    // ------------------------------------------------------------
    assign cfu_cond = s2_fu[p_fu_cfu] && (s2_uop[4:3] == cfu_cond_code);
    // Stores and branches write nothing, trap keeps rd as cause
    assign no_rd    = ((s2_fu[p_fu_lsu] && s2_uop[lsu_store]) || cfu_cond) && !s2_trap;

    always_comb begin
        n_s3.rd    = no_rd ? '0 : s2_rd;
        n_s3.pc    = program_counter;
        n_s3.uop   = s2_uop;
        n_s3.fu    = s2_fu;
        n_s3.size  = s2_size;
        n_s3.instr = s2_instr;
        n_s3.opr_a = ({xlen{s2_opr_src[dis_opra_rs1]}}  & dis_rs1)     |
                     ({xlen{s2_opr_src[dis_opra_pcim]}} & pc_plus_imm) |
                     ({xlen{s2_opr_src[dis_opra_csri]}} & csr_imm);
        n_s3.opr_b = ({xlen{s2_opr_src[dis_oprb_rs2]}}  & dis_rs2)     |
                     ({xlen{s2_opr_src[dis_oprb_imm]}}  & s2_imm);
        n_s3.opr_c = ({xlen{s2_opr_src[dis_oprc_rs2]}}  & dis_rs2)     |
                     ({xlen{s2_opr_src[dis_oprc_csra]}} & csr_addr)    |
                     ({xlen{s2_opr_src[dis_oprc_pcim]}} & pc_plus_imm);
        n_s3.trap  = s2_trap;
    end

    // ------------------------------------------------------------
    // Submodules
    // ------------------------------------------------------------
    dis_gprs i_gprs (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .rs1_addr (s2_rs1),
        .rs1_data (gpr_rs1),
        .rs2_addr (s2_rs2),
        .rs2_data (gpr_rs2),
        .rd_wen   (gpr_wen),
        .rd_addr  (gpr_rd),
        .rd_data  (gpr_wdata)
    );

    dis_pipe_reg i_pipe_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_data   (n_s3),
        .i_valid  (p_valid),
        .o_busy   (p_busy),
        .flush    (p_flush),
        .o_data   (s3_data),
        .o_valid  (s3_valid),
        .i_busy   (s3_busy)
    );

endmodule

`default_nettype wire

// File: hdl/dis_backend_top.sv
// Backend dispatch top level, plain ports around the dispatch stage
`timescale 1ns/10ps
`default_nettype none

module dis_backend_top #(
    parameter dis_pkg::word_t pc_reset_value = 32'h8000_0000
) (
    input  wire                g_clk,
    input  wire                g_resetn,
    input  wire                s2_valid,
    output logic               s2_busy,
    input  dis_pkg::reg_addr_t s2_rd,
    input  dis_pkg::reg_addr_t s2_rs1,
    input  dis_pkg::reg_addr_t s2_rs2,
    input  dis_pkg::word_t     s2_imm,
    input  wire [4:0]          s2_uop,
    input  wire [4:0]          s2_fu,
    input  wire                s2_trap,
    input  wire [7:0]          s2_opr_src,
    input  wire [1:0]          s2_size,
    input  wire [31:0]         s2_instr,
    input  wire                flush,
    input  wire                cf_req,
    input  dis_pkg::word_t     cf_target,
    input  wire                cf_ack,
    input  dis_pkg::reg_addr_t fwd_s3_rd,
    input  dis_pkg::word_t     fwd_s3_wdata,
    input  wire                fwd_s3_load,
    input  wire                fwd_s3_csr,
    input  dis_pkg::reg_addr_t fwd_s4_rd,
    input  dis_pkg::word_t     fwd_s4_wdata,
    input  wire                fwd_s4_load,
    input  wire                fwd_s4_csr,
    input  wire                gpr_wen,
    input  dis_pkg::reg_addr_t gpr_rd,
    input  dis_pkg::word_t     gpr_wdata,
    input  wire                s3_busy,
    output logic               s3_valid,
    output dis_pkg::reg_addr_t s3_rd,
    output dis_pkg::word_t     s3_pc,
    output logic [4:0]         s3_uop,
    output logic [4:0]         s3_fu,
    output logic [1:0]         s3_size,
    output logic [31:0]        s3_instr,
    output dis_pkg::word_t     s3_opr_a,
    output dis_pkg::word_t     s3_opr_b,
    output dis_pkg::word_t     s3_opr_c,
    output logic               s3_trap
);
    import dis_pkg::*;

    dis_s3_t   s3_data;                       // Packed execute payload
    dis_fwd_if fwd_s3 ();                     // Execute stage forward path
    dis_fwd_if fwd_s4 ();                     // Writeback stage forward path

    // ------------------------------------------------------------
    // Forwarding bundles
    // ------------------------------------------------------------
    assign fwd_s3.rd    = fwd_s3_rd;
    assign fwd_s3.wdata = fwd_s3_wdata;
    assign fwd_s3.load  = fwd_s3_load;
    assign fwd_s3.csr   = fwd_s3_csr;
    assign fwd_s4.rd    = fwd_s4_rd;
    assign fwd_s4.wdata = fwd_s4_wdata;
    assign fwd_s4.load  = fwd_s4_load;
    assign fwd_s4.csr   = fwd_s4_csr;

    dis_dispatch #(
        .pc_reset_value (pc_reset_value)
    ) i_dispatch (
        .g_clk      (g_clk),      .g_resetn   (g_resetn),
        .s2_valid   (s2_valid),   .s2_busy    (s2_busy),
        .s2_rd      (s2_rd),      .s2_rs1     (s2_rs1),
        .s2_rs2     (s2_rs2),     .s2_imm     (s2_imm),
        .s2_uop     (s2_uop),     .s2_fu      (s2_fu),
        .s2_trap    (s2_trap),    .s2_opr_src (s2_opr_src),
        .s2_size    (s2_size),    .s2_instr   (s2_instr),
        .flush      (flush),      .cf_req     (cf_req),
        .cf_target  (cf_target),  .cf_ack     (cf_ack),
        .fwd_s3     (fwd_s3),     .fwd_s4     (fwd_s4),
        .gpr_wen    (gpr_wen),    .gpr_rd     (gpr_rd),
        .gpr_wdata  (gpr_wdata),  .s3_busy    (s3_busy),
        .s3_valid   (s3_valid),   .s3_data    (s3_data)
    );

    // Unpack payload onto the execute ports
    assign {s3_rd, s3_pc, s3_uop, s3_fu, s3_size, s3_instr,
            s3_opr_a, s3_opr_b, s3_opr_c, s3_trap} = s3_data;

endmodule

`default_nettype wire

// File: tb/dis_tb_clk.sv
// Testbench clock and reset source, 8 ns clock with reset held for three cycles
`timescale 1ns/10ps
`default_nettype none

module dis_tb_clk (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;            // 8 ns period
    end

    initial begin
        g_resetn = 1'b0;                      // Reset active from time zero
        repeat (3) @(posedge g_clk);
        g_resetn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/dis_sva.sv
// Dispatch checker with register shadow, PC model and concurrent assertions
`timescale 1ns/10ps
`default_nettype none

module dis_sva #(
    parameter dis_pkg::word_t pc_reset_value = 32'h8000_0000
) (
    input wire                g_clk,
    input wire                g_resetn,
    input wire                s2_valid,
    input wire                s2_busy,
    input dis_pkg::reg_addr_t s2_rd,
    input dis_pkg::reg_addr_t s2_rs1,
    input dis_pkg::reg_addr_t s2_rs2,
    input wire [4:0]          s2_uop,
    input wire [4:0]          s2_fu,
    input wire                s2_trap,
    input wire [7:0]          s2_opr_src,
    input wire [1:0]          s2_size,
    input wire [31:0]         s2_instr,
    input wire                flush,
    input wire                cf_req,
    input dis_pkg::word_t     cf_target,
    input wire                cf_ack,
    input dis_pkg::reg_addr_t fwd_s3_rd,
    input dis_pkg::word_t     fwd_s3_wdata,
    input wire                fwd_s3_load,
    input wire                fwd_s3_csr,
    input dis_pkg::reg_addr_t fwd_s4_rd,
    input dis_pkg::word_t     fwd_s4_wdata,
    input wire                fwd_s4_csr,
    input wire                gpr_wen,
    input dis_pkg::reg_addr_t gpr_rd,
    input dis_pkg::word_t     gpr_wdata,
    input wire                s3_busy,
    input wire                s3_valid,
    input dis_pkg::reg_addr_t s3_rd,
    input dis_pkg::word_t     s3_pc,
    input wire [4:0]          s3_uop,
    input wire [4:0]          s3_fu,
    input wire [1:0]          s3_size,
    input wire [31:0]         s3_instr,
    input dis_pkg::word_t     s3_opr_a,
    input dis_pkg::word_t     s3_opr_b,
    input dis_pkg::word_t     s3_opr_c,
    input wire                s3_trap
);
    import dis_pkg::*;

    int      fail_count = 0;                  // Read by the testbench top
    word_t   shadow [32];                     // Expected register contents
    word_t   exp_pc;                          // Expected decode PC
    word_t   exp_a, exp_b;
    reg_addr_t exp_rd;
    logic    accepted, hazard, a_rs1_only, b_rs2_only, c_rs2_only;

    // ------------------------------------------------------------
    // Reference models
    // ------------------------------------------------------------
    always @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else if (gpr_wen && gpr_rd != '0) begin
            shadow[gpr_rd] <= gpr_wdata;      // x0 never written
        end
    end

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            exp_pc <= pc_reset_value;
        end else if (cf_req && cf_ack) begin
            exp_pc <= cf_target;              // Redirect first
        end else if (s2_valid && !s2_busy) begin
            exp_pc <= exp_pc + (s2_size[1] ? 32'd4 : 32'd2);
        end
    end

    // Priority s3, then s4, then register, x0 is zero
    function automatic word_t src_value(input reg_addr_t idx);
        if (idx == '0) return '0;
        if (idx == fwd_s3_rd) return fwd_s3_wdata;
        if (idx == fwd_s4_rd) return fwd_s4_wdata;
        return shadow[idx];
    endfunction

    assign accepted   = s2_valid && !s2_busy && !flush;
    assign a_rs1_only = s2_opr_src[dis_opra_rs1] && !s2_opr_src[dis_opra_pcim] &&
                        !s2_opr_src[dis_opra_csri];
    assign b_rs2_only = s2_opr_src[dis_oprb_rs2] && !s2_opr_src[dis_oprb_imm];
    assign c_rs2_only = s2_opr_src[dis_oprc_rs2] && !s2_opr_src[dis_oprc_csra] &&
                        !s2_opr_src[dis_oprc_pcim];

    always_comb begin
        exp_a = src_value(s2_rs1);
        exp_b = src_value(s2_rs2);
    end

    assign exp_rd     = (((s2_fu[p_fu_lsu] && s2_uop[lsu_store]) ||
                          (s2_fu[p_fu_cfu] && s2_uop[4:3] == 2'b00)) && !s2_trap) ? '0 : s2_rd;
    assign hazard     = ((fwd_s3_load || fwd_s3_csr) &&
                         (s2_rs1 == fwd_s3_rd || s2_rs2 == fwd_s3_rd)) ||
                        (fwd_s4_csr && (s2_rs1 == fwd_s4_rd || s2_rs2 == fwd_s4_rd));

    // ------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------
    a_reset_empty: assert property (@(posedge g_clk) !g_resetn |=> !s3_valid)
        else begin
            fail_count++;
            $error("s3_valid high after reset");
        end

    a_pc: assert property (@(posedge g_clk) disable iff (!g_resetn)
        accepted |=> s3_valid && s3_pc == $past(exp_pc))
        else begin
            fail_count++;
            $error("s3_pc mismatch, time %0t", $time);
        end

    a_payload: assert property (@(posedge g_clk) disable iff (!g_resetn)
        accepted |=> {s3_uop, s3_fu, s3_size, s3_instr, s3_trap} ==
                     $past({s2_uop, s2_fu, s2_size, s2_instr, s2_trap}))
        else begin
            fail_count++;
            $error("s3 payload fields mismatch, time %0t", $time);
        end

    a_opr_a: assert property (@(posedge g_clk) disable iff (!g_resetn)
        accepted && a_rs1_only |=> s3_opr_a == $past(exp_a))
        else begin
            fail_count++;
            $error("operand A mismatch, time %0t", $time);
        end

    a_opr_b: assert property (@(posedge g_clk) disable iff (!g_resetn)
        accepted && b_rs2_only |=> s3_opr_b == $past(exp_b))
        else begin
            fail_count++;
            $error("operand B mismatch, time %0t", $time);
        end

    a_opr_c: assert property (@(posedge g_clk) disable iff (!g_resetn)
        accepted && c_rs2_only |=> s3_opr_c == $past(exp_b))
        else begin
            fail_count++;
            $error("operand C mismatch, time %0t", $time);
        end

    a_hazard_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        hazard |-> s2_busy)
        else begin
            fail_count++;
            $error("hazard without s2_busy, time %0t", $time);
        end

    a_bubble: assert property (@(posedge g_clk) disable iff (!g_resetn)
        hazard && !(s3_valid && s3_busy) |=> !s3_valid)
        else begin
            fail_count++;
            $error("instruction passed a hazard, time %0t", $time);
        end

    a_rd: assert property (@(posedge g_clk) disable iff (!g_resetn)
        accepted |=> s3_rd == $past(exp_rd))
        else begin
            fail_count++;
            $error("s3_rd mismatch, time %0t", $time);
        end

    a_hold_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s3_valid && s3_busy |-> s2_busy)
        else begin
            fail_count++;
            $error("s2_busy low while held, time %0t", $time);
        end

    a_hold_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s3_valid && s3_busy && !flush |=> s3_valid &&
        $stable({s3_rd, s3_pc, s3_uop, s3_fu, s3_size, s3_instr,
                 s3_opr_a, s3_opr_b, s3_opr_c, s3_trap}))
        else begin
            fail_count++;
            $error("s3 outputs moved while held, time %0t", $time);
        end

    a_flush: assert property (@(posedge g_clk) disable iff (!g_resetn)
        flush |=> !s3_valid)
        else begin
            fail_count++;
            $error("s3_valid high after flush, time %0t", $time);
        end

endmodule

`default_nettype wire

// File: tb/dis_tb.sv
// Dispatch testbench top with random stimulus, per-test report and run limit
`timescale 1ns/10ps
`default_nettype none

module dis_tb;
    import dis_pkg::*;

    localparam int    n_tests         = 6;
    localparam int    cycles_per_test = 150;
    localparam int    timeout_cycles  = n_tests * (cycles_per_test + 10) + 40;
    localparam word_t pc_start        = 32'h8000_0000;

    logic g_clk, g_resetn;
    logic s2_valid, s2_busy, s2_trap, flush, cf_req, cf_ack;
    reg_addr_t s2_rd, s2_rs1, s2_rs2, fwd_s3_rd, fwd_s4_rd, gpr_rd, s3_rd;
    word_t s2_imm, cf_target, fwd_s3_wdata, fwd_s4_wdata, gpr_wdata;
    logic [4:0] s2_uop, s2_fu, s3_uop, s3_fu;
    logic [7:0] s2_opr_src;
    logic [1:0] s2_size, s3_size;
    logic [31:0] s2_instr, s3_instr;
    logic fwd_s3_load, fwd_s3_csr, fwd_s4_load, fwd_s4_csr, gpr_wen, s3_busy;
    logic s3_valid, s3_trap;
    word_t s3_pc, s3_opr_a, s3_opr_b, s3_opr_c;
    int cycles = 0;
    int failed_tests = 0;

    dis_tb_clk i_clk (.g_clk(g_clk), .g_resetn(g_resetn));

    dis_backend_top #(.pc_reset_value(pc_start)) DUT (.*);

    bind dis_backend_top dis_sva #(.pc_reset_value(pc_reset_value)) u_sva (.*);

    // Run limit
    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Stimulus, one cycle per call
    // ------------------------------------------------------------
    task automatic drive_cycle(input int test_id);
        @(posedge g_clk);
        // New instruction only once the last one was taken
        if (!s2_valid || !s2_busy) begin
            s2_valid   <= ($urandom % 4) != 0;
            s2_rd      <= reg_addr_t'($urandom % 8);
            s2_rs1     <= reg_addr_t'($urandom % 8);
            s2_rs2     <= reg_addr_t'($urandom % 8);
            s2_imm     <= $urandom;
            s2_size    <= ($urandom % 2) ? 2'b10 : 2'b01;
            s2_instr   <= $urandom;
            s2_uop     <= 5'($urandom);
            s2_fu      <= 5'b1 << ($urandom % 5);
            s2_trap    <= (test_id == 5) && ($urandom % 4 == 0);
            s2_opr_src <= (test_id == 5) ? 8'($urandom) : 8'b0000_1001;
        end
        fwd_s3_rd    <= reg_addr_t'($urandom % 8);
        fwd_s4_rd    <= reg_addr_t'($urandom % 8);
        fwd_s3_wdata <= $urandom;
        fwd_s4_wdata <= $urandom;
        fwd_s3_load  <= (test_id == 4) && ($urandom % 3 == 0);
        fwd_s3_csr   <= (test_id == 4) && ($urandom % 4 == 0);
        fwd_s4_csr   <= (test_id == 4) && ($urandom % 4 == 0);
        gpr_wen      <= (test_id >= 3) && ($urandom % 2 == 0);
        gpr_rd       <= reg_addr_t'($urandom % 8);
        gpr_wdata    <= $urandom;
        cf_req       <= (test_id == 2) && ($urandom % 6 == 0);
        cf_ack       <= (test_id == 2) && ($urandom % 2 == 0);
        cf_target    <= $urandom & 32'hffff_fffe;  // Halfword aligned
        s3_busy      <= (test_id == 6) && ($urandom % 2 == 0);
        flush        <= (test_id == 6) && ($urandom % 10 == 0);
    endtask

    task automatic run_test(input int test_id, input string name);
        int errs_before;
        errs_before = DUT.u_sva.fail_count;
        repeat (cycles_per_test) drive_cycle(test_id);
        repeat (4) drive_cycle(0);            // Drain with quiet controls
        if (DUT.u_sva.fail_count == errs_before) begin
            $display("test %0d %s: ok", test_id, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d assertion failures", test_id, name,
                     DUT.u_sva.fail_count - errs_before);
        end
    endtask

    initial begin
        void'($urandom(32'h3f7b_44a7));
        s2_valid = 0; s2_rd = '0; s2_rs1 = '0; s2_rs2 = '0; s2_imm = '0;
        s2_uop = '0; s2_fu = '0; s2_trap = 0; s2_opr_src = '0; s2_size = 2'b10;
        s2_instr = '0; flush = 0; cf_req = 0; cf_target = '0; cf_ack = 0;
        fwd_s3_rd = '0; fwd_s3_wdata = '0; fwd_s3_load = 0; fwd_s3_csr = 0;
        fwd_s4_rd = '0; fwd_s4_wdata = '0; fwd_s4_load = 0; fwd_s4_csr = 0;
        gpr_wen = 0; gpr_rd = '0; gpr_wdata = '0; s3_busy = 0;
        wait (g_resetn === 1'b1);
        run_test(1, "reset and first pc");
        run_test(2, "pc step and redirect");
        run_test(3, "operand forwarding");
        run_test(4, "hazard bubbles");
        run_test(5, "rd zeroing");
        run_test(6, "stall and flush");
        $display("tests %0d, failed %0d, assertion failures %0d",
                 n_tests, failed_tests, DUT.u_sva.fail_count);
        if (failed_tests == 0 && DUT.u_sva.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: frv_dispatch.f
hdl/dis_pkg.sv
hdl/dis_fwd_if.sv
hdl/dis_gprs.sv
hdl/dis_pipe_reg.sv
hdl/dis_dispatch.sv
hdl/dis_backend_top.sv
tb/dis_tb_clk.sv
tb/dis_sva.sv
tb/dis_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the dispatch testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f frv_dispatch.f --top-module dis_tb -o dis_sim
./obj_dir/dis_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -q "^sim passed$" sim.log; then
    exit 0
fi
exit 1
